// File: hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem
(
	input logic clk,
	input logic rst_n,
	dmem_if.mem_mp dmem
);
	import ldst_pkg::*;

	word_t                 mem [MEM_DEPTH];
	logic [MEM_ADDR_W-1:0] rd_idx;
	word_t                 rd_word;
	logic                  lat_done;

	initial
	begin
		$readmemh(MEM_INIT_FILE, mem);
	end

	// Writes land in the strobe cycle
	always_ff @(posedge clk)
	begin
		if (dmem.write)
			mem[mem_index(dmem.addr)] <= dmem.wdata;
	end

	always_ff @(posedge clk)
	begin
		if (dmem.read)
			rd_idx <= mem_index(dmem.addr);
		rd_word <= mem[rd_idx];
	end

	mem_wait_timer lat_timer
	(
		.clk   (clk),
		.rst_n (rst_n),
		.start (dmem.read || dmem.write),
		.done  (lat_done)
	);

	// Read word is settled well before ready
	assign dmem.rdata = rd_word;
	assign dmem.ready = lat_done;

endmodule

// File: hdl/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;
	import ldst_pkg::*;

	logic  read;
	logic  write;
	word_t addr;
	word_t wdata;
	word_t rdata;
	logic  ready;

	modport ctrl_mp
	(
		output read, write, addr, wdata,
		input  rdata, ready
	);

	modport mem_mp
	(
		input  read, write, addr, wdata,
		output rdata, ready
	);

endinterface

// File: hdl/ldst_ctrl.sv
`timescale 1ns/1ps

module ldst_ctrl
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  logic              issue,
	input  ldst_pkg::opcode_t opcode,
	input  ldst_pkg::tag_t    dest,
	input  ldst_pkg::word_t   eff_addr,
	input  ldst_pkg::word_t   store_data,
	input  logic              operands_ready,
	output logic              capture,
	dmem_if.ctrl_mp           dmem,
	output logic              busy,
	output logic              cdb_out_valid,
	output ldst_pkg::tag_t    cdb_out_tag,
	output ldst_pkg::word_t   cdb_out_data
);
	import ldst_pkg::*;

	typedef enum logic [1:0]
	{
		st_idle,
		st_wait,
		st_access,
		st_bcast
	} state_t;

	state_t state;
	state_t state_next;
	logic   is_load;
	logic   is_store;
	logic   start_access;
	logic   access_done;

	assign is_load  = opcode == op_ldr;
	assign is_store = opcode == op_str;

	// New work is taken only from idle
	assign capture = state == st_idle && issue && !flush;

	// One strobe, in the first ready cycle of WAIT
	assign start_access = state == st_wait && operands_ready && !flush;
	assign access_done  = state == st_access && dmem.ready;

	assign dmem.read  = start_access && is_load;
	assign dmem.write = start_access && is_store;
	assign dmem.addr  = eff_addr;
	assign dmem.wdata = store_data;

	assign busy = state != st_idle;

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (capture)
					state_next = st_wait;
			st_wait:
			begin
				// Unknown opcodes are accepted and dropped here
				if (!is_load && !is_store)
					state_next = st_idle;
				else if (operands_ready)
					state_next = st_access;
			end
			st_access:
				if (dmem.ready)
					state_next = is_load ? st_bcast : st_idle;
			st_bcast:
				state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
		if (flush)
			state_next = st_idle;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state         <= st_idle;
			cdb_out_valid <= 1'b0;
		end
		else
		begin
			state         <= state_next;
			cdb_out_valid <= access_done && is_load && !flush;
		end
	end

	// Result and tag for the outgoing CDB
	always_ff @(posedge clk)
	begin
		if (access_done)
		begin
			cdb_out_tag  <= dest;
			cdb_out_data <= dmem.rdata;
		end
	end

endmodule

// File: hdl/ldst_pkg.sv
package ldst_pkg;

	// Datapath widths
	localparam int WORD_W = 16;
	localparam int TAG_W  = 3;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0]  tag_t;

	// Tag 0 marks an operand with no producer
	localparam tag_t TAG_NONE = '0;

	// Only LDR and STR are executed, anything else is dropped
	typedef enum logic [3:0]
	{
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} opcode_t;

	// Data memory geometry
	localparam int MEM_ADDR_W = 8;
	localparam int MEM_DEPTH  = 256;

	// Access time in cycles from strobe to ready
	localparam int MEM_LATENCY = 3;

	// Wide enough to hold MEM_LATENCY-1
	localparam int TIMER_W = $clog2(MEM_LATENCY + 1);

	localparam string MEM_INIT_FILE = "mem_init.hex";

	// Word index from a byte address, bit 0 is ignored
	function automatic logic [MEM_ADDR_W-1:0] mem_index(input word_t addr);
		return addr[MEM_ADDR_W:1];
	endfunction

endpackage

// File: hdl/ldst_station.sv
`timescale 1ns/1ps

module ldst_station
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  logic              capture,
	input  ldst_pkg::opcode_t issue_opcode,
	input  ldst_pkg::word_t   issue_base,
	input  logic              issue_base_valid,
	input  ldst_pkg::tag_t    issue_base_tag,
	input  ldst_pkg::word_t   issue_src,
	input  logic              issue_src_valid,
	input  ldst_pkg::tag_t    issue_src_tag,
	input  ldst_pkg::word_t   issue_offset,
	input  ldst_pkg::tag_t    issue_dest,
	input  logic              cdb_in_valid,
	input  ldst_pkg::tag_t    cdb_in_tag,
	input  ldst_pkg::word_t   cdb_in_data,
	output ldst_pkg::opcode_t opcode,
	output ldst_pkg::tag_t    dest,
	output ldst_pkg::word_t   eff_addr,
	output ldst_pkg::word_t   store_data,
	output logic              operands_ready
);
	import ldst_pkg::*;

	word_t offset_q;
	word_t base_value;
	logic  base_valid;
	logic  src_valid;

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			opcode   <= issue_opcode;
			offset_q <= issue_offset;
			dest     <= issue_dest;
		end
	end

	operand_slot base_slot
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.load       (capture),
		.load_value (issue_base),
		.load_valid (issue_base_valid),
		.load_tag   (issue_base_tag),
		.cdb_valid  (cdb_in_valid),
		.cdb_tag    (cdb_in_tag),
		.cdb_data   (cdb_in_data),
		.value      (base_value),
		.valid      (base_valid)
	);

	operand_slot src_slot
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.load       (capture),
		.load_value (issue_src),
		.load_valid (issue_src_valid),
		.load_tag   (issue_src_tag),
		.cdb_valid  (cdb_in_valid),
		.cdb_tag    (cdb_in_tag),
		.cdb_data   (cdb_in_data),
		.value      (store_data),
		.valid      (src_valid)
	);

	assign eff_addr = base_value + offset_q;

	// A store also needs its source word
	always_comb
	begin
		case (opcode)
			op_ldr:  operands_ready = base_valid;
			op_str:  operands_ready = base_valid && src_valid;
			default: operands_ready = 1'b0;
		endcase
	end

endmodule

// File: hdl/ldst_unit.sv
`timescale 1ns/1ps

module ldst_unit
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  logic              issue,
	input  ldst_pkg::opcode_t issue_opcode,
	input  ldst_pkg::word_t   issue_base,
	input  logic              issue_base_valid,
	input  ldst_pkg::tag_t    issue_base_tag,
	input  ldst_pkg::word_t   issue_src,
	input  logic              issue_src_valid,
	input  ldst_pkg::tag_t    issue_src_tag,
	input  ldst_pkg::word_t   issue_offset,
	input  ldst_pkg::tag_t    issue_dest,
	input  logic              cdb_in_valid,
	input  ldst_pkg::tag_t    cdb_in_tag,
	input  ldst_pkg::word_t   cdb_in_data,
	output logic              busy,
	output logic              cdb_out_valid,
	output ldst_pkg::tag_t    cdb_out_tag,
	output ldst_pkg::word_t   cdb_out_data
);
	import ldst_pkg::*;

	logic    capture;
	opcode_t opcode;
	tag_t    dest;
	word_t   eff_addr;
	word_t   store_data;
	logic    operands_ready;

	dmem_if dmem ();

	ldst_station station_i
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.flush            (flush),
		.capture          (capture),
		.issue_opcode     (issue_opcode),
		.issue_base       (issue_base),
		.issue_base_valid (issue_base_valid),
		.issue_base_tag   (issue_base_tag),
		.issue_src        (issue_src),
		.issue_src_valid  (issue_src_valid),
		.issue_src_tag    (issue_src_tag),
		.issue_offset     (issue_offset),
		.issue_dest       (issue_dest),
		.cdb_in_valid     (cdb_in_valid),
		.cdb_in_tag       (cdb_in_tag),
		.cdb_in_data      (cdb_in_data),
		.opcode           (opcode),
		.dest             (dest),
		.eff_addr         (eff_addr),
		.store_data       (store_data),
		.operands_ready   (operands_ready)
	);

	ldst_ctrl ctrl_i
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.issue          (issue),
		.opcode         (opcode),
		.dest           (dest),
		.eff_addr       (eff_addr),
		.store_data     (store_data),
		.operands_ready (operands_ready),
		.capture        (capture),
		.dmem           (dmem.ctrl_mp),
		.busy           (busy),
		.cdb_out_valid  (cdb_out_valid),
		.cdb_out_tag    (cdb_out_tag),
		.cdb_out_data   (cdb_out_data)
	);

	data_mem dmem_i
	(
		.clk   (clk),
		.rst_n (rst_n),
		.dmem  (dmem.mem_mp)
	);

endmodule

// File: hdl/mem_wait_timer.sv
`timescale 1ns/1ps

module mem_wait_timer
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);
	import ldst_pkg::*;

	logic [TIMER_W-1:0] count;
	logic               active;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			count  <= '0;
		end
		else if (start)
		begin
			// Restart on every strobe
			active <= 1'b1;
			count  <= TIMER_W'(MEM_LATENCY - 1);
		end
		else if (active)
		begin
			if (count == '0)
				active <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign done = active && count == '0;

endmodule

// File: hdl/operand_slot.sv
`timescale 1ns/1ps

module operand_slot
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  logic            load,
	input  ldst_pkg::word_t load_value,
	input  logic            load_valid,
	input  ldst_pkg::tag_t  load_tag,
	input  logic            cdb_valid,
	input  ldst_pkg::tag_t  cdb_tag,
	input  ldst_pkg::word_t cdb_data,
	output ldst_pkg::word_t value,
	output logic            valid
);
	import ldst_pkg::*;

	tag_t tag_q;
	logic cdb_hit;

	// Snoop only while waiting on a real producer
	assign cdb_hit = !valid && cdb_valid && tag_q != TAG_NONE && cdb_tag == tag_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
			valid <= 1'b0;
		else if (load)
			valid <= load_valid;
		else if (cdb_hit)
			valid <= 1'b1;
	end

	// Issue data wins over a broadcast in the same cycle
	always_ff @(posedge clk)
	begin
		if (load)
			value <= load_value;
		else if (cdb_hit)
			value <= cdb_data;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			tag_q <= load_tag;
	end

endmodule

// File: mem_init.hex
// One 16-bit data word per line in hex, for word addresses 0 to 15
5a3c
1f07
c0de
0042
7e91
b3a8
2d64
9f10
04ce
e715
6b2f
3890
a4d3
0c7b
f1e6
8255

// File: project.f
hdl/ldst_pkg.sv
hdl/dmem_if.sv
hdl/operand_slot.sv
hdl/ldst_station.sv
hdl/mem_wait_timer.sv
hdl/data_mem.sv
hdl/ldst_ctrl.sv
hdl/ldst_unit.sv
tests/ldst_unit_asserts.sv
tests/ldst_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ldst_unit_tb \
	-f project.f -Mdir obj_dir -o ldst_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/ldst_sim > "$LOG" 2>&1 || echo "ERRORS FOUND" >> "$LOG"
cat "$LOG"

grep -q "ERRORS FOUND" "$LOG" && { echo "Simulation failed"; exit 1; } \
	|| echo "Simulation passed"

// File: tests/ldst_unit_asserts.sv
`timescale 1ns/1ps

module ldst_unit_asserts
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic busy,
	input logic cdb_out_valid,
	input logic read,
	input logic write
);

	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
		else $error("read and write strobes high together");

	// Broadcast is a single-cycle pulse
	a_bcast_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_out_valid |=> !cdb_out_valid)
		else $error("cdb_out_valid held for more than one cycle");

	a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy)
		else $error("busy still high in the cycle after flush");

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !(read || write))
		else $error("memory strobe while the unit is idle");

endmodule

bind ldst_ctrl ldst_unit_asserts asserts_i
(
	.clk           (clk),
	.rst_n         (rst_n),
	.flush         (flush),
	.busy          (busy),
	.cdb_out_valid (cdb_out_valid),
	.read          (dmem.read),
	.write         (dmem.write)
);

// File: tests/ldst_unit_tb.sv
`timescale 1ns/1ps

module ldst_unit_tb;
	import ldst_pkg::*;

	// Run limit covers the longest test with margin
	localparam int N_TESTS     = 40;
	localparam int CYCLE_LIMIT = N_TESTS * (MEM_LATENCY + 20);
	localparam int WAIT_LIMIT  = MEM_LATENCY + 10;

	logic    clk;
	logic    rst_n;
	logic    flush;
	logic    issue;
	opcode_t issue_opcode;
	word_t   issue_base;
	logic    issue_base_valid;
	tag_t    issue_base_tag;
	word_t   issue_src;
	logic    issue_src_valid;
	tag_t    issue_src_tag;
	word_t   issue_offset;
	tag_t    issue_dest;
	logic    cdb_in_valid;
	tag_t    cdb_in_tag;
	word_t   cdb_in_data;
	logic    busy;
	logic    cdb_out_valid;
	tag_t    cdb_out_tag;
	word_t   cdb_out_data;

	word_t       ref_mem [MEM_DEPTH];
	logic [31:0] lfsr;
	tag_t        exp_tags [$];
	word_t       exp_words [$];
	int          errors = 0;
	int          tests = 0;
	int          failed_tests = 0;
	int          test_base = 0;
	int          cycles = 0;
	int          bcast_count = 0;

	ldst_unit dut_i (.*);

	always #50 clk = ~clk;

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], next_bit()};
		return v;
	endfunction

	function automatic tag_t rand_tag();
		tag_t t;
		t = tag_t'(rand_bits(3));
		if (t == TAG_NONE)
			t = 3'd7;
		return t;
	endfunction

	function automatic tag_t other_tag(input tag_t t);
		return (t == 3'd7) ? 3'd1 : t + 3'd1;
	endfunction

	// Bits 8 to 1 of the byte address pick the expected word
	function automatic word_t ref_load(input word_t addr);
		return ref_mem[addr[8:1]];
	endfunction

	task automatic ref_store(input word_t addr, input word_t data);
		ref_mem[addr[8:1]] = data;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tag(input string name, input tag_t got, input tag_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic issue_op(input opcode_t op, input word_t base, input logic base_valid,
		input tag_t base_tag, input word_t src, input logic src_valid, input tag_t src_tag,
		input word_t offset, input tag_t dest, output logic accepted);
		@(negedge clk);
		issue_opcode     = op;
		issue_base       = base;
		issue_base_valid = base_valid;
		issue_base_tag   = base_tag;
		issue_src        = src;
		issue_src_valid  = src_valid;
		issue_src_tag    = src_tag;
		issue_offset     = offset;
		issue_dest       = dest;
		issue            = 1'b1;
		accepted         = !busy;
		@(negedge clk);
		issue = 1'b0;
	endtask

	task automatic send_cdb(input tag_t tag, input word_t data);
		@(negedge clk);
		cdb_in_valid = 1'b1;
		cdb_in_tag   = tag;
		cdb_in_data  = data;
		@(negedge clk);
		cdb_in_valid = 1'b0;
	endtask

	task automatic pulse_flush();
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic expect_bcast(input tag_t tag, input word_t data);
		exp_tags.push_back(tag);
		exp_words.push_back(data);
	endtask

	task automatic expect_busy(input logic exp, input string what);
		if (busy !== exp)
		begin
			$display("Busy flag wrong, %s", what);
			errors++;
		end
	endtask

	task automatic wait_bcast();
		int start;
		int n;
		start = bcast_count;
		n     = 0;
		while (bcast_count == start && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (bcast_count == start)
		begin
			$display("No broadcast came out within %0d cycles", WAIT_LIMIT);
			errors++;
			exp_tags.delete();
			exp_words.delete();
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
		begin
			$display("Unit stayed busy for %0d cycles", WAIT_LIMIT);
			errors++;
		end
	endtask

	// Load through a random offset and check the broadcast
	task automatic load_check(input word_t addr);
		word_t offset;
		tag_t  dest;
		logic  acc;
		offset = rand_bits(8) << 1;
		dest   = rand_tag();
		expect_bcast(dest, ref_load(addr));
		issue_op(op_ldr, addr - offset, 1'b1, TAG_NONE, '0, 1'b0, TAG_NONE,
			offset, dest, acc);
		if (!acc)
		begin
			$display("Load issue was refused although the unit was idle");
			errors++;
		end
		wait_bcast();
		wait_idle();
	endtask

	task automatic begin_test();
		test_base = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_base)
			$display("test %0d %s: ok", tests, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", tests, name, errors - test_base);
		end
	endtask

	// Registered outputs are sampled on the rising edge before they change
	always @(posedge clk)
	begin
		if (rst_n && cdb_out_valid)
		begin
			if (exp_tags.size() == 0)
			begin
				$display("Unexpected broadcast with tag %h data %h", cdb_out_tag, cdb_out_data);
				errors++;
			end
			else
			begin
				check_tag("cdb_out_tag", cdb_out_tag, exp_tags.pop_front());
				check_word("cdb_out_data", cdb_out_data, exp_words.pop_front());
			end
			bcast_count++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		word_t   addr;
		word_t   offset;
		word_t   data;
		tag_t    dest;
		tag_t    ptag;
		logic    acc;
		opcode_t second_op;

		clk              = 1'b0;
		rst_n            = 1'b0;
		flush            = 1'b0;
		issue            = 1'b0;
		issue_opcode     = op_ldr;
		issue_base       = '0;
		issue_base_valid = 1'b0;
		issue_base_tag   = TAG_NONE;
		issue_src        = '0;
		issue_src_valid  = 1'b0;
		issue_src_tag    = TAG_NONE;
		issue_offset     = '0;
		issue_dest       = TAG_NONE;
		cdb_in_valid     = 1'b0;
		cdb_in_tag       = TAG_NONE;
		cdb_in_data      = '0;
		lfsr             = 32'h38af_6bf6;
		$readmemh(MEM_INIT_FILE, ref_mem);
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < 12; i++)
		begin
			begin_test();
			load_check(rand_bits(4) << 1);
			end_test("load with ready base");
		end

		for (int i = 0; i < 6; i++)
		begin
			begin_test();
			addr   = rand_bits(8) << 1;
			offset = rand_bits(8) << 1;
			data   = rand_bits(16);
			issue_op(op_str, addr - offset, 1'b1, TAG_NONE, data, 1'b1, TAG_NONE,
				offset, TAG_NONE, acc);
			wait_idle();
			ref_store(addr, data);
			load_check(addr);
			end_test("store then load");
		end

		for (int i = 0; i < 2; i++)
		begin
			begin_test();
			addr   = rand_bits(4) << 1;
			offset = rand_bits(8) << 1;
			dest   = rand_tag();
			ptag   = rand_tag();
			issue_op(op_ldr, 16'hdead, 1'b0, ptag, '0, 1'b0, TAG_NONE, offset, dest, acc);
			send_cdb(other_tag(ptag), 16'hbeef);
			idle_cycles(MEM_LATENCY + 3);
			expect_busy(1'b1, "load left the station before its base arrived");
			expect_bcast(dest, ref_load(addr));
			send_cdb(ptag, addr - offset);
			wait_bcast();
			wait_idle();
			end_test("load with pending base");
		end

		for (int i = 0; i < 2; i++)
		begin
			begin_test();
			addr   = rand_bits(8) << 1;
			offset = rand_bits(8) << 1;
			data   = rand_bits(16);
			ptag   = rand_tag();
			issue_op(op_str, addr - offset, 1'b1, TAG_NONE, 16'h0bad, 1'b0, ptag,
				offset, TAG_NONE, acc);
			idle_cycles(MEM_LATENCY);
			expect_busy(1'b1, "store left the station before its data arrived");
			send_cdb(ptag, data);
			wait_idle();
			ref_store(addr, data);
			load_check(addr);
			end_test("store with pending source");
		end

		for (int i = 0; i < 2; i++)
		begin
			begin_test();
			ptag = rand_tag();
			issue_op(op_ldr, 16'hdead, 1'b0, ptag, '0, 1'b0, TAG_NONE,
				rand_bits(8) << 1, rand_tag(), acc);
			idle_cycles(2);
			pulse_flush();
			expect_busy(1'b0, "still high in the cycle after flush");
			send_cdb(ptag, 16'h0010);
			idle_cycles(MEM_LATENCY + 4);
			expect_busy(1'b0, "flushed load came back");
			end_test("flush of a waiting load");
		end

		for (int i = 0; i < 2; i++)
		begin
			begin_test();
			addr   = rand_bits(4) << 1;
			offset = rand_bits(8) << 1;
			ptag   = rand_tag();
			issue_op(op_str, addr - offset, 1'b1, TAG_NONE, '0, 1'b0, ptag,
				offset, TAG_NONE, acc);
			idle_cycles(1);
			pulse_flush();
			expect_busy(1'b0, "still high in the cycle after flush");
			send_cdb(ptag, rand_bits(16));
			idle_cycles(MEM_LATENCY + 2);
			load_check(addr);
			end_test("flush of a waiting store");
		end

		// Second issue hits a busy unit as a load and then as a store
		for (int i = 0; i < 2; i++)
		begin
			begin_test();
			addr   = rand_bits(4) << 1;
			offset = rand_bits(8) << 1;
			dest   = rand_tag();
			expect_bcast(dest, ref_load(addr));
			issue_op(op_ldr, addr - offset, 1'b1, TAG_NONE, '0, 1'b0, TAG_NONE,
				offset, dest, acc);
			if (i == 0)
				second_op = op_ldr;
			else
				second_op = op_str;
			issue_op(second_op, addr - offset, 1'b1, TAG_NONE,
				rand_bits(16), 1'b1, TAG_NONE, offset, other_tag(dest), acc);
			if (acc)
			begin
				$display("Issue was accepted while the unit was busy");
				errors++;
			end
			wait_bcast();
			wait_idle();
			idle_cycles(MEM_LATENCY + 2);
			load_check(addr);
			end_test("issue while busy");
		end

		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
